//--- files.f
+incdir+bench
source/camera_pkg.sv
source/ccd_capture.sv
source/line_buffer.sv
source/raw_to_rgb.sv
source/pixel_packer.sv
source/frame_count_display.sv
source/camera_capture_top.sv
bench/clock_gen.sv
bench/camera_capture_tb.sv

//--- Makefile
SOURCES := files.f $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vcamera_capture_tb: $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module camera_capture_tb -f files.f

run: obj_dir/Vcamera_capture_tb
	./obj_dir/Vcamera_capture_tb | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/camera_ref.svh
`ifndef CAMERA_REF_SVH
`define CAMERA_REF_SVH

// ==========================================================================
// Expected frame-buffer words for one 2x2 Bayer block
// ==========================================================================

// Top ten of the twelve raw bits
function automatic int unsigned ten_bit(input int unsigned sample);
	return sample / 4;
endfunction

// Mean of the two greens, rounded down
function automatic int unsigned green_avg(input int unsigned upper_left,
	input int unsigned lower_right);
	return (upper_left + lower_right) / 2;
endfunction

// Upper half of green, then blue
function automatic word_t expected_word1(input raw_pixel_t upper_left,
	input raw_pixel_t lower_left, input raw_pixel_t lower_right);
	int unsigned green;
	green = ten_bit(green_avg(32'(upper_left), 32'(lower_right)));
	return word_t'((green / 32) * 1024 + ten_bit(32'(lower_left)));
endfunction

// Lower half of green, then red
function automatic word_t expected_word2(input raw_pixel_t upper_left,
	input raw_pixel_t upper_right, input raw_pixel_t lower_right);
	int unsigned green;
	green = ten_bit(green_avg(32'(upper_left), 32'(lower_right)));
	return word_t'((green % 32) * 1024 + ten_bit(32'(upper_right)));
endfunction

// ==========================================================================
// Expected seven-segment patterns
// ==========================================================================

// Lit segments gfedcba, inverted for the active-low display
function automatic logic [6:0] seg_pattern(input int unsigned nibble);
	logic [6:0] lit;
	case (nibble)
		0: lit = 7'h3f;
		1: lit = 7'h06;
		2: lit = 7'h5b;
		3: lit = 7'h4f;
		4: lit = 7'h66;
		5: lit = 7'h6d;
		6: lit = 7'h7d;
		7: lit = 7'h07;
		8: lit = 7'h7f;
		9: lit = 7'h6f;
		10: lit = 7'h77;
		11: lit = 7'h7c;
		12: lit = 7'h39;
		13: lit = 7'h5e;
		14: lit = 7'h79;
		default: lit = 7'h71;
	endcase
	return ~lit;
endfunction

function automatic logic [63:0] hex_pattern(input int unsigned count);
	logic [63:0] pattern;
	pattern = '0;
	for (int n = 0; n < NUM_DIGITS; n++)
		pattern[SEG_BITS*n +: SEG_BITS] = seg_pattern((count >> (4*n)) % 16);
	return pattern;
endfunction

`endif

//--- bench/camera_capture_tb.sv
`timescale 1ns/100ps
`default_nettype none

module camera_capture_tb import camera_pkg::*; ();

	localparam int LINE_WIDTH     = 16;
	localparam int FRAME_WIDTH    = 16;
	localparam int FRAME_LINES    = 6;
	localparam int DRIVE_DELAY    = 10;
	localparam int RESET_TIMEOUT  = 50;
	localparam int DRAIN_TIMEOUT  = 200;
	localparam int WRITE_LATENCY  = 4;
	localparam logic [31:0] SEED  = 32'h29d1_0eae;

	`include "camera_ref.svh"

	wire D5M_PIXLCLK;
	wire reset;

	raw_pixel_t d5m_data;
	logic       d5m_fval;
	logic       d5m_lval;
	logic       start_pulse;
	logic       end_pulse;
	word_t      wr_data1;
	word_t      wr_data2;
	logic       wr_en;
	logic [NUM_DIGITS-1:0][SEG_BITS-1:0] hex;

	clock_gen #(
		.HALF_PERIOD  (100),
		.RESET_CYCLES (8)
	) clock_gen_i (
		.o_clk   (D5M_PIXLCLK),
		.o_reset (reset)
	);

	camera_capture_top #(
		.LINE_WIDTH (LINE_WIDTH)
	) camera_capture_top_i (
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.i_reset     (reset),
		.D5M_D       (d5m_data),
		.D5M_FVAL    (d5m_fval),
		.D5M_LVAL    (d5m_lval),
		.i_start     (start_pulse),
		.i_end       (end_pulse),
		.o_wr_data1  (wr_data1),
		.o_wr_data2  (wr_data2),
		.o_wr_en     (wr_en),
		.o_hex       (hex)
	);

	// ======================================================================
	// Scoreboard state
	// ======================================================================

	raw_pixel_t  frame_mem [0:FRAME_LINES-1][0:FRAME_WIDTH-1];
	word_t       exp_word1_q [$];
	word_t       exp_word2_q [$];
	int unsigned exp_cycle_q [$];
	int unsigned cycle_count = 0;
	int unsigned checks = 0;
	int unsigned errors = 0;
	int unsigned frames_captured = 0;
	bit          armed = 1'b0;
	bit          timed_out = 1'b0;

	always @(posedge D5M_PIXLCLK)
		cycle_count <= cycle_count + 1;

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic check_display();
		check_value("o_hex", 64'(hex), hex_pattern(frames_captured));
	endtask

	// ======================================================================
	// Sensor model
	// ======================================================================

	task automatic next_cycle();
		@(posedge D5M_PIXLCLK);
		#(DRIVE_DELAY);
	endtask

	// Line valid low and junk on the data pins
	task automatic idle_cycles(input int unsigned n);
		for (int unsigned i = 0; i < n; i++)
		begin
			d5m_lval    = 1'b0;
			d5m_data    = raw_pixel_t'($urandom());
			start_pulse = 1'b0;
			end_pulse   = 1'b0;
			next_cycle();
		end
	endtask

	// One cycle pulse on start or end between frames
	task automatic pulse_control(input bit arm);
		start_pulse = arm;
		end_pulse   = !arm;
		armed       = arm;
		next_cycle();
		idle_cycles(2);
	endtask

	task automatic send_frame(input bit start_mid, input bit end_mid);
		bit         captured;
		raw_pixel_t sample;
		captured = armed;
		if (captured)
			frames_captured++;
		d5m_fval = 1'b1;
		idle_cycles(1 + ($urandom() % 3));
		for (int y = 0; y < FRAME_LINES; y++)
		begin
			for (int x = 0; x < FRAME_WIDTH; x++)
			begin
				sample = raw_pixel_t'($urandom());
				frame_mem[y][x] = sample;
				// Control pulses land in the middle of line 2
				if (y == 2 && x == 4)
				begin
					start_pulse = start_mid;
					end_pulse   = end_mid;
					if (start_mid)
						armed = 1'b1;
					if (end_mid)
						armed = 1'b0;
				end
				else
				begin
					start_pulse = 1'b0;
					end_pulse   = 1'b0;
				end
				d5m_lval = 1'b1;
				d5m_data = sample;
				if (captured && (x % 2 == 1) && (y % 2 == 1))
				begin
					exp_word1_q.push_back(expected_word1(frame_mem[y-1][x-1],
						frame_mem[y][x-1], sample));
					exp_word2_q.push_back(expected_word2(frame_mem[y-1][x-1],
						frame_mem[y-1][x], sample));
					exp_cycle_q.push_back(cycle_count);
				end
				next_cycle();
			end
			idle_cycles(1 + ($urandom() % 4));
		end
		d5m_fval = 1'b0;
		idle_cycles(3 + ($urandom() % 6));
	endtask

	// ======================================================================
	// Waits
	// ======================================================================

	task automatic wait_reset_release();
		int unsigned waited;
		waited = 0;
		@(posedge D5M_PIXLCLK);
		while (reset && waited < RESET_TIMEOUT)
		begin
			@(posedge D5M_PIXLCLK);
			waited++;
		end
		if (reset)
		begin
			$display("Timeout: reset was never released");
			errors++;
			timed_out = 1'b1;
		end
		#(DRIVE_DELAY);
	endtask

	task automatic wait_for_drain();
		int unsigned waited;
		waited = 0;
		while (exp_cycle_q.size() != 0 && waited < DRAIN_TIMEOUT)
		begin
			next_cycle();
			waited++;
		end
		if (exp_cycle_q.size() != 0)
		begin
			$display("Timeout: %0d expected writes never arrived", exp_cycle_q.size());
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// ======================================================================
	// Compare process
	// ======================================================================

	always @(negedge D5M_PIXLCLK)
	begin : compare_writes
		word_t       word1;
		word_t       word2;
		int unsigned pushed_at;
		if (!reset && wr_en)
		begin
			if (exp_cycle_q.size() == 0)
			begin
				$display("Unexpected write at %0t with no block pending", $time);
				errors++;
			end
			else
			begin
				word1     = exp_word1_q.pop_front();
				word2     = exp_word2_q.pop_front();
				pushed_at = exp_cycle_q.pop_front();
				check_value("o_wr_data1", 64'(wr_data1), 64'(word1));
				check_value("o_wr_data2", 64'(wr_data2), 64'(word2));
				check_value("o_wr_en latency", 64'(cycle_count - pushed_at),
					64'(WRITE_LATENCY));
			end
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial
	begin
		d5m_data    = '0;
		d5m_fval    = 1'b0;
		d5m_lval    = 1'b0;
		start_pulse = 1'b0;
		end_pulse   = 1'b0;
		void'($urandom(SEED));

		wait_reset_release();
		if (!timed_out)
		begin
			// Not armed yet so the frame is ignored
			check_display();
			send_frame(1'b0, 1'b0);
			check_display();

			// Start mid frame and writes begin with the next one
			send_frame(1'b1, 1'b0);
			check_display();
			repeat (3)
			begin
				send_frame(1'b0, 1'b0);
				check_display();
			end

			// End mid frame lets this one finish
			send_frame(1'b0, 1'b1);
			check_display();
			send_frame(1'b0, 1'b0);
			check_display();

			// Count runs past 0xf to show every nibble pattern
			pulse_control(1'b1);
			repeat (12)
			begin
				send_frame(1'b0, 1'b0);
				check_display();
			end
			pulse_control(1'b0);
			send_frame(1'b0, 1'b0);
			check_display();

			wait_for_drain();
			idle_cycles(10);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen
#(
	parameter int HALF_PERIOD  = 100,
	parameter int RESET_CYCLES = 8
)
(
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = ~o_clk;
	end

	// Released a little after a rising edge, like the other inputs
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#10 o_reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- source/camera_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module camera_capture_top import camera_pkg::*;
#(
	parameter int LINE_WIDTH = 1280
)
(
	input  wire                                  D5M_PIXLCLK,
	input  wire                                  i_reset,
	input  wire  raw_pixel_t                     D5M_D,
	input  wire                                  D5M_FVAL,
	input  wire                                  D5M_LVAL,
	input  wire                                  i_start,
	input  wire                                  i_end,
	output word_t                                o_wr_data1,
	output word_t                                o_wr_data2,
	output logic                                 o_wr_en,
	output logic [NUM_DIGITS-1:0][SEG_BITS-1:0] o_hex
);

	// ======================================================================
	// Input side
	// ======================================================================

	raw_pixel_t            pixel;
	logic                  pixel_valid;
	coord_t                x_cont;
	coord_t                y_cont;
	logic [FRAME_BITS-1:0] frame_count;

	ccd_capture ccd_capture_i (
		.D5M_PIXLCLK   (D5M_PIXLCLK),
		.i_reset       (i_reset),
		.i_d5m_data    (D5M_D),
		.i_d5m_fval    (D5M_FVAL),
		.i_d5m_lval    (D5M_LVAL),
		.i_start       (i_start),
		.i_end         (i_end),
		.o_pixel       (pixel),
		.o_pixel_valid (pixel_valid),
		.o_x           (x_cont),
		.o_y           (y_cont),
		.o_frame_count (frame_count)
	);

	// ======================================================================
	// Demosaic
	// ======================================================================

	chan_t rgb_red;
	chan_t rgb_green;
	chan_t rgb_blue;
	logic  rgb_valid;

	raw_to_rgb #(
		.LINE_WIDTH (LINE_WIDTH)
	) raw_to_rgb_i (
		.D5M_PIXLCLK   (D5M_PIXLCLK),
		.i_reset       (i_reset),
		.i_pixel       (pixel),
		.i_pixel_valid (pixel_valid),
		.i_x           (x_cont),
		.i_y           (y_cont),
		.o_red         (rgb_red),
		.o_green       (rgb_green),
		.o_blue        (rgb_blue),
		.o_rgb_valid   (rgb_valid)
	);

	// ======================================================================
	// Output side
	// ======================================================================

	pixel_packer pixel_packer_i (
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.i_reset     (i_reset),
		.i_red       (rgb_red),
		.i_green     (rgb_green),
		.i_blue      (rgb_blue),
		.i_rgb_valid (rgb_valid),
		.o_wr_data1  (o_wr_data1),
		.o_wr_data2  (o_wr_data2),
		.o_wr_en     (o_wr_en)
	);

	// Frame counter on the hex digits
	frame_count_display frame_count_display_i (
		.i_frame_count (frame_count),
		.o_hex         (o_hex)
	);

endmodule

`default_nettype wire

//--- source/frame_count_display.sv
`timescale 1ns/100ps
`default_nettype none

module frame_count_display import camera_pkg::*;
(
	input  wire  [FRAME_BITS-1:0]                i_frame_count,
	output logic [NUM_DIGITS-1:0][SEG_BITS-1:0] o_hex
);

	// Active low, segment a in bit 0
	function automatic logic [SEG_BITS-1:0] hex_to_seg(input logic [3:0] nibble);
		logic [SEG_BITS-1:0] seg;
		case (nibble)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'ha: seg = 7'b0001000;
			4'hb: seg = 7'b0000011;
			4'hc: seg = 7'b1000110;
			4'hd: seg = 7'b0100001;
			4'he: seg = 7'b0000110;
			default: seg = 7'b0001110;
		endcase
		return seg;
	endfunction

	// Digit n shows nibble n
	always_comb
	begin
		for (int n = 0; n < NUM_DIGITS; n++)
		begin
			o_hex[n] = hex_to_seg(i_frame_count[4*n +: 4]);
		end
	end

endmodule

`default_nettype wire

//--- source/pixel_packer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_packer import camera_pkg::*;
(
	input  wire        D5M_PIXLCLK,
	input  wire        i_reset,
	input  wire chan_t i_red,
	input  wire chan_t i_green,
	input  wire chan_t i_blue,
	input  wire        i_rgb_valid,
	output word_t      o_wr_data1,
	output word_t      o_wr_data2,
	output logic       o_wr_en
);

	localparam int HALF_BITS = CHAN_BITS / 2;

	logic [CHAN_BITS-1:0] red;
	logic [CHAN_BITS-1:0] green;
	logic [CHAN_BITS-1:0] blue;

	// Keep the top bits of each channel
	assign red   = i_red[RAW_BITS-1 -: CHAN_BITS];
	assign green = i_green[RAW_BITS-1 -: CHAN_BITS];
	assign blue  = i_blue[RAW_BITS-1 -: CHAN_BITS];

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_reset)
			o_wr_en <= 1'b0;
		else
			o_wr_en <= i_rgb_valid;
	end

	// Green is split over the two words
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_rgb_valid)
		begin
			o_wr_data1 <= {1'b0, green[CHAN_BITS-1 -: HALF_BITS], blue};
			o_wr_data2 <= {1'b0, green[HALF_BITS-1:0], red};
		end
	end

endmodule

`default_nettype wire

//--- source/raw_to_rgb.sv
`timescale 1ns/100ps
`default_nettype none

module raw_to_rgb import camera_pkg::*;
#(
	parameter int LINE_WIDTH = 1280
)
(
	input  wire             D5M_PIXLCLK,
	input  wire             i_reset,
	input  wire raw_pixel_t i_pixel,
	input  wire             i_pixel_valid,
	input  wire coord_t     i_x,
	input  wire coord_t     i_y,
	output chan_t           o_red,
	output chan_t           o_green,
	output chan_t           o_blue,
	output logic            o_rgb_valid
);

	// ======================================================================
	// Line delay
	// ======================================================================

	raw_pixel_t above;

	line_buffer #(
		.LINE_WIDTH (LINE_WIDTH)
	) line_buffer_i (
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.i_wr_en     (i_pixel_valid),
		.i_addr      (i_x),
		.i_data      (i_pixel),
		.o_data      (above)
	);

	// ======================================================================
	// Neighbour samples
	// ======================================================================

	// Left neighbour on this line and on the line above
	raw_pixel_t prev_pix;
	raw_pixel_t prev_above;

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_pixel_valid)
		begin
			prev_pix   <= i_pixel;
			prev_above <= above;
		end
	end

	// ======================================================================
	// Block close and RGB output
	// ======================================================================

	// Sensor order is G R on even rows, B G on odd rows
	logic              block_close;
	logic [RAW_BITS:0] green_sum;

	assign block_close = i_pixel_valid && i_x[0] && i_y[0];

	// Upper-left green plus current green, one extra bit for the carry
	assign green_sum = {1'b0, prev_above} + {1'b0, i_pixel};

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_reset)
			o_rgb_valid <= 1'b0;
		else
			o_rgb_valid <= block_close;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (block_close)
		begin
			o_red   <= above;
			o_blue  <= prev_pix;
			o_green <= green_sum[RAW_BITS:1];
		end
	end

endmodule

`default_nettype wire

//--- source/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module line_buffer import camera_pkg::*;
#(
	parameter int LINE_WIDTH = 1280
)
(
	input  wire             D5M_PIXLCLK,
	input  wire             i_wr_en,
	input  wire coord_t     i_addr,
	input  wire raw_pixel_t i_data,
	output raw_pixel_t      o_data
);

	localparam int ADDR_BITS = $clog2(LINE_WIDTH);

	// One sensor line of raw samples
	raw_pixel_t mem [0:LINE_WIDTH-1];

	logic [ADDR_BITS-1:0] addr;

	assign addr = i_addr[ADDR_BITS-1:0];

	// Read is asynchronous, so the old sample is seen before the write lands
	assign o_data = mem[addr];

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_wr_en)
			mem[addr] <= i_data;
	end

endmodule

`default_nettype wire

//--- source/ccd_capture.sv
`timescale 1ns/100ps
`default_nettype none

module ccd_capture import camera_pkg::*;
(
	input  wire                   D5M_PIXLCLK,
	input  wire                   i_reset,
	input  wire  raw_pixel_t      i_d5m_data,
	input  wire                   i_d5m_fval,
	input  wire                   i_d5m_lval,
	input  wire                   i_start,
	input  wire                   i_end,
	output raw_pixel_t            o_pixel,
	output logic                  o_pixel_valid,
	output coord_t                o_x,
	output coord_t                o_y,
	output logic [FRAME_BITS-1:0] o_frame_count
);

	// ======================================================================
	// Sensor pin registers
	// ======================================================================

	raw_pixel_t r_data;
	logic       r_fval;
	logic       r_lval;
	logic       r_fval_d;
	logic       r_lval_d;

	always_ff @(posedge D5M_PIXLCLK)
	begin
		r_data <= i_d5m_data;
		if (i_reset)
		begin
			r_fval   <= 1'b0;
			r_lval   <= 1'b0;
			r_fval_d <= 1'b0;
			r_lval_d <= 1'b0;
		end
		else
		begin
			r_fval   <= i_d5m_fval;
			r_lval   <= i_d5m_lval;
			r_fval_d <= r_fval;
			r_lval_d <= r_lval;
		end
	end

	// ======================================================================
	// Arm and frame gating
	// ======================================================================

	logic armed;
	logic frame_active;
	logic fval_rise;
	logic lval_fall;
	logic take_frame;
	logic take_pixel;

	assign fval_rise = r_fval && !r_fval_d;
	assign lval_fall = r_lval_d && !r_lval;

	// A frame is only taken if armed when it starts
	assign take_frame = fval_rise ? armed : frame_active;
	assign take_pixel = take_frame && r_fval && r_lval;

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_reset)
		begin
			armed         <= 1'b0;
			frame_active  <= 1'b0;
			o_frame_count <= '0;
		end
		else
		begin
			if (i_start)
				armed <= 1'b1;
			else if (i_end)
				armed <= 1'b0;

			// Running frame always completes, end only blocks the next one
			if (fval_rise)
				frame_active <= armed;
			else if (!r_fval)
				frame_active <= 1'b0;

			if (fval_rise && armed)
				o_frame_count <= o_frame_count + 1'b1;
		end
	end

	// ======================================================================
	// Column and line counters, pixel output
	// ======================================================================

	coord_t x_cnt;
	coord_t y_cnt;

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (i_reset)
		begin
			x_cnt         <= '0;
			y_cnt         <= '0;
			o_pixel_valid <= 1'b0;
		end
		else
		begin
			o_pixel_valid <= take_pixel;

			if (take_pixel)
				x_cnt <= x_cnt + 1'b1;
			else if (!r_lval)
				x_cnt <= '0;

			if (!r_fval)
				y_cnt <= '0;
			else if (lval_fall)
				y_cnt <= y_cnt + 1'b1;
		end
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (take_pixel)
		begin
			o_pixel <= r_data;
			o_x     <= x_cnt;
			o_y     <= y_cnt;
		end
	end

endmodule

`default_nettype wire

//--- source/camera_pkg.sv
`default_nettype none

// ==========================================================================
// Widths and pixel types for the D5M camera path
// ==========================================================================

package camera_pkg;

	// Raw sensor sample
	localparam int RAW_BITS   = 12;
	// Channel width stored in the frame buffer, top bits kept
	localparam int CHAN_BITS  = 10;
	localparam int WORD_BITS  = 16;
	localparam int COORD_BITS = 16;
	localparam int FRAME_BITS = 32;

	// Seven-segment display
	localparam int SEG_BITS   = 7;
	localparam int NUM_DIGITS = 8;

	typedef logic [RAW_BITS-1:0]   raw_pixel_t;
	typedef logic [COORD_BITS-1:0] coord_t;
	// Full precision colour channel between demosaic and packer
	typedef logic [RAW_BITS-1:0]   chan_t;
	typedef logic [WORD_BITS-1:0]  word_t;

endpackage

`default_nettype wire
